// ==== project.f ====
src/layer_geom_pkg.sv
src/axi_read_pkg.sv
src/axi_read_master.sv
src/row_fetch_scheduler.sv
src/row_bank.sv
src/window_streamer.sv
src/input_layer_reader.sv
verification/ddr_read_model.sv
verification/tb_input_layer_reader.sv

// ==== verification/tb_input_layer_reader.sv ====
// testbench for the input layer reader
// runs a table of layer geometries back to back after one reset
// checks each window against the padding and layout rules, each AR burst
// address and length, the arvalid and rready handshakes and the run_done pulse

module tb_input_layer_reader;

	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT_CYCLES = 20000;

	logic                    clk;
	logic                    reset_n;
	logic                    start;
	axi_read_pkg::addr_t     base_address;
	layer_geom_pkg::count_t  num_layers;
	layer_geom_pkg::count_t  num_rows;
	layer_geom_pkg::count_t  num_cols;
	logic [3:0]              row_beats;
	logic [15:0]             row_pitch;
	axi_read_pkg::addr_t     araddr;
	logic [7:0]              arlen;
	logic                    arvalid;
	logic                    arready;
	logic                    rvalid;
	layer_geom_pkg::beat_t   rdata;
	logic                    rlast;
	logic                    rready;
	layer_geom_pkg::window_t window_data;
	logic                    window_valid;
	logic                    window_ready;
	logic                    run_done;
	logic                    ar_stall;
	logic                    r_stall;

	int   seed = 18156;
	int   errors;
	int   test_errors;
	int   tests_failed;
	logic timed_out;

	// test table, one entry per run
	string               t_name [NUM_TESTS];
	int                  t_layers [NUM_TESTS];
	int                  t_rows [NUM_TESTS];
	int                  t_cols [NUM_TESTS];
	int                  t_beats [NUM_TESTS];
	int                  t_pitch [NUM_TESTS];
	axi_read_pkg::addr_t t_base [NUM_TESTS];
	int                  t_ready_pct [NUM_TESTS];
	int                  t_stall_pct [NUM_TESTS];
	int                  t_windows [NUM_TESTS];

	layer_geom_pkg::window_t exp_windows [$];
	axi_read_pkg::addr_t     exp_bursts [$];

	input_layer_reader i_input_layer_reader (
		.clk(clk), .reset_n(reset_n), .start(start), .base_address(base_address),
		.num_layers(num_layers), .num_rows(num_rows), .num_cols(num_cols),
		.row_beats(row_beats), .row_pitch(row_pitch), .araddr(araddr), .arlen(arlen),
		.arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rdata(rdata),
		.rlast(rlast), .rready(rready), .window_data(window_data),
		.window_valid(window_valid), .window_ready(window_ready), .run_done(run_done)
	);

	ddr_read_model i_ddr_read_model (
		.clk(clk), .reset_n(reset_n), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
		.arready(arready), .rvalid(rvalid), .rdata(rdata), .rlast(rlast), .rready(rready),
		.ar_stall(ar_stall), .r_stall(r_stall)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------------------------------------
	// table and reference model
	// --------------------------------------------------
	task automatic add_entry(input int i, input string name, input int layers, input int rows,
		input int cols, input int beats, input int pitch, input axi_read_pkg::addr_t base,
		input int ready_pct, input int stall_pct, input int windows);
		t_name[i] = name;
		t_layers[i] = layers;
		t_rows[i] = rows;
		t_cols[i] = cols;
		t_beats[i] = beats;
		t_pitch[i] = pitch;
		t_base[i] = base;
		t_ready_pct[i] = ready_pct;
		t_stall_pct[i] = stall_pct;
		t_windows[i] = windows;
	endtask

	task automatic load_table();
		// layers rows cols beats pitch base ready% stall% windows
		add_entry(0, "single layer", 1, 4, 6, 1, 16, 32'h0000_1000, 100, 0, 24);
		add_entry(1, "several layers", 3, 5, 12, 2, 64, 32'h0002_0000, 100, 0, 180);
		add_entry(2, "padding", 2, 2, 16, 2, 24, 32'h0004_0008, 100, 0, 64);
		add_entry(3, "back-pressure", 2, 4, 10, 2, 40, 32'h0000_8000, 30, 0, 80);
		add_entry(4, "axi stalls", 2, 3, 9, 2, 16, 32'h0001_0000, 100, 50, 54);
		add_entry(5, "restart", 1, 1, 5, 1, 8, 32'h0003_0100, 70, 30, 5);
	endtask

	// memory contents, byte at a is a mod 251
	function automatic logic [7:0] mem_byte(input axi_read_pkg::addr_t a);
		return 8'(a % 251);
	endfunction

	function automatic layer_geom_pkg::window_t expected_window(input int t, input int layer,
		input int row, input int col);
		layer_geom_pkg::window_t w;
		int rr;
		int cc;
		axi_read_pkg::addr_t row_addr;
		w = '0;
		for (int k = 0; k < 3; k++) begin
			rr = row - 1 + k;
			for (int j = 0; j < 3; j++) begin
				cc = col + j;
				// rows outside the layer and columns past cols stay zero
				if (rr >= 0 && rr < t_rows[t] && cc < t_cols[t]) begin
					row_addr = t_base[t] + layer * 4096 + rr * t_pitch[t];
					// lane cc mod 8 of beat cc div 8 is byte row_addr + cc
					w[71 - 24*k - 8*j -: 8] = mem_byte(row_addr + cc);
				end
			end
		end
		return w;
	endfunction

	// row outer, layer inner; taps r-1, r, r+1 fetched when in range
	task automatic build_expected(input int t);
		int rr;
		exp_windows.delete();
		exp_bursts.delete();
		for (int r = 0; r < t_rows[t]; r++) begin
			for (int l = 0; l < t_layers[t]; l++) begin
				for (int k = 0; k < 3; k++) begin
					rr = r - 1 + k;
					if (rr >= 0 && rr < t_rows[t]) begin
						exp_bursts.push_back(t_base[t] + l * 4096 + rr * t_pitch[t]);
					end
				end
				for (int c = 0; c < t_cols[t]; c++) begin
					exp_windows.push_back(expected_window(t, l, r, c));
				end
			end
		end
	endtask

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic check_window(input string name, input layer_geom_pkg::window_t expected,
		input layer_geom_pkg::window_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_address(input string name, input axi_read_pkg::addr_t expected,
		input axi_read_pkg::addr_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_length(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: expected %b, got %b", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("%0t %s", $time, what);
		errors++;
		test_errors++;
	endtask

	// --------------------------------------------------
	// one table entry, start to run_done
	// --------------------------------------------------
	task automatic run_test(input int t);
		int got;
		int cycles;
		int burst_base;
		int n_bursts;
		int done_pulses;
		logic expect_done;
		logic finished;
		logic in_flight;
		logic ar_wait;
		test_errors = 0;
		build_expected(t);
		burst_base = i_ddr_read_model.burst_count;
		@(posedge clk);
		base_address <= t_base[t];
		num_layers   <= layer_geom_pkg::count_t'(t_layers[t]);
		num_rows     <= layer_geom_pkg::count_t'(t_rows[t]);
		num_cols     <= layer_geom_pkg::count_t'(t_cols[t]);
		row_beats    <= 4'(t_beats[t]);
		row_pitch    <= 16'(t_pitch[t]);
		start        <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		got = 0;
		cycles = 0;
		done_pulses = 0;
		expect_done = 1'b0;
		finished = 1'b0;
		in_flight = 1'b0;
		ar_wait = 1'b0;
		// wait for run_done, checking every cycle window_valid is high
		while (!finished && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			window_ready <= ({$random(seed)} % 100) < t_ready_pct[t];
			ar_stall     <= ({$random(seed)} % 100) < t_stall_pct[t];
			r_stall      <= ({$random(seed)} % 100) < t_stall_pct[t];
			@(negedge clk);
			cycles++;
			// rready high only while a burst is in flight
			check_flag("rready", in_flight, rready);
			// arvalid holds until arready
			if (ar_wait) begin
				check_flag("arvalid", 1'b1, arvalid);
			end
			ar_wait = arvalid && !arready;
			if (arvalid && arready) begin
				in_flight = 1'b1;
			end
			if (rvalid && rready && rlast) begin
				in_flight = 1'b0;
			end
			if (run_done) begin
				done_pulses++;
				finished = 1'b1;
				if (!expect_done) begin
					report_problem("run_done pulsed before the last window was accepted");
				end
			end else if (expect_done) begin
				report_problem("run_done missing in the cycle after the last window");
				finished = 1'b1;
			end
			if (window_valid) begin
				if (got >= exp_windows.size()) begin
					report_problem("window_valid high after all windows were accepted");
				end else begin
					check_window("window_data", exp_windows[got], window_data);
				end
				// transfer on the coming edge
				if (window_ready) begin
					got++;
					expect_done = got == exp_windows.size();
				end
			end
		end
		if (!finished) begin
			$display("timeout in test %0d waiting for run_done, %0d windows taken", t, got);
			timed_out = 1'b1;
		end
		// a few quiet cycles, no second pulse
		repeat (4) begin
			@(negedge clk);
			if (run_done || window_valid) begin
				report_problem("run_done or window_valid active after the run ended");
			end
		end
		check_count("accepted windows", t_windows[t], got);
		check_count("run_done pulses", 1, done_pulses);
		n_bursts = i_ddr_read_model.burst_count - burst_base;
		check_count("AR bursts", exp_bursts.size(), n_bursts);
		for (int i = 0; i < n_bursts && i < exp_bursts.size(); i++) begin
			check_address("araddr", exp_bursts[i], i_ddr_read_model.burst_addr[burst_base + i]);
			check_length("arlen", 8'(t_beats[t] - 1), i_ddr_read_model.burst_len[burst_base + i]);
		end
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d windows, %0d bursts, %0d errors",
			t, t_name[t], got, n_bursts, test_errors);
	endtask

	initial begin
		errors = 0;
		test_errors = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		reset_n = 1'b0;
		start = 1'b0;
		base_address = '0;
		num_layers = '0;
		num_rows = '0;
		num_cols = '0;
		row_beats = '0;
		row_pitch = '0;
		window_ready = 1'b0;
		ar_stall = 1'b0;
		r_stall = 1'b0;
		load_table();
		repeat (15) @(posedge clk);
		// outputs idle while reset is held
		@(negedge clk);
		check_flag("arvalid", 1'b0, arvalid);
		check_flag("rready", 1'b0, rready);
		check_flag("window_valid", 1'b0, window_valid);
		check_flag("run_done", 1'b0, run_done);
		@(posedge clk);
		reset_n <= 1'b1;
		// no reset between entries, later ones restart the DUT
		for (int t = 0; t < NUM_TESTS; t++) begin
			if (!timed_out) begin
				run_test(t);
			end
		end
		$display("%0d tests, %0d failed, %0d errors, timeout %0d",
			NUM_TESTS, tests_failed, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verification/ddr_read_model.sv ====
// AXI4 read slave for the layer reader testbench
// byte at address a reads as a mod 251, beats are 8 bytes, lane 0 low
// stall inputs insert arready and rvalid gaps, every AR burst is logged

module ddr_read_model #(
	parameter int LOG_DEPTH = 1024
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  axi_read_pkg::addr_t   araddr,
	input  logic [7:0]            arlen,
	input  logic                  arvalid,
	output logic                  arready,
	output logic                  rvalid,
	output layer_geom_pkg::beat_t rdata,
	output logic                  rlast,
	input  logic                  rready,
	input  logic                  ar_stall,
	input  logic                  r_stall
);

	// burst log, read by the testbench
	axi_read_pkg::addr_t burst_addr [LOG_DEPTH];
	logic [7:0]          burst_len [LOG_DEPTH];
	int                  burst_count;

	logic                active;
	axi_read_pkg::addr_t start_addr;
	logic [7:0]          last_idx;
	logic [7:0]          beat_idx;
	logic [7:0]          next_idx;

	function automatic layer_geom_pkg::beat_t beat_at(input axi_read_pkg::addr_t addr);
		layer_geom_pkg::beat_t b;
		for (int j = 0; j < axi_read_pkg::BEAT_BYTES; j++) begin
			b[8*j +: 8] = 8'((addr + axi_read_pkg::addr_t'(j)) % 251);
		end
		return b;
	endfunction

	// beat to present, moves on after each transfer
	assign next_idx = (rvalid && rready) ? beat_idx + 8'd1 : beat_idx;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			arready     <= 1'b0;
			rvalid      <= 1'b0;
			rlast       <= 1'b0;
			rdata       <= '0;
			active      <= 1'b0;
			beat_idx    <= '0;
			burst_count <= 0;
		end else begin
			arready <= 1'b0;
			if (!active) begin
				if (arvalid && arready) begin
					if (burst_count < LOG_DEPTH) begin
						burst_addr[burst_count] <= araddr;
						burst_len[burst_count]  <= arlen;
					end
					burst_count <= burst_count + 1;
					active      <= 1'b1;
					start_addr  <= araddr;
					last_idx    <= arlen;
					beat_idx    <= '0;
				end else if (arvalid && !ar_stall) begin
					arready <= 1'b1;
				end
			end else if (rvalid && rready && rlast) begin
				// burst done, one outstanding at a time
				rvalid <= 1'b0;
				rlast  <= 1'b0;
				active <= 1'b0;
			end else if (!rvalid || rready) begin
				// a held beat stays until rready
				beat_idx <= next_idx;
				rvalid   <= !r_stall;
				rdata    <= beat_at(start_addr + (axi_read_pkg::addr_t'(next_idx) << 3));
				rlast    <= next_idx == last_idx;
			end
		end
	end

endmodule

// ==== src/input_layer_reader.sv ====
// top level of the input layer reader
// fetches feature-map rows over AXI4 read into three ping-pong row banks
// and streams padded 3x3 windows on a valid/ready interface

module input_layer_reader #(
	parameter int MAX_ROW_BEATS = 8,
	parameter int ADDR_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    reset_n,

	// run configuration
	input  logic                    start,
	input  axi_read_pkg::addr_t     base_address,
	input  layer_geom_pkg::count_t  num_layers,
	input  layer_geom_pkg::count_t  num_rows,
	input  layer_geom_pkg::count_t  num_cols,
	input  logic [3:0]              row_beats,
	input  logic [15:0]             row_pitch,

	// AXI4 read
	output logic [ADDR_WIDTH-1:0]   araddr,
	output logic [7:0]              arlen,
	output logic                    arvalid,
	input  logic                    arready,
	input  logic                    rvalid,
	input  layer_geom_pkg::beat_t   rdata,
	input  logic                    rlast,
	output logic                    rready,

	// window stream
	output layer_geom_pkg::window_t window_data,
	output logic                    window_valid,
	input  logic                    window_ready,
	output logic                    run_done
);

	localparam int AW = $clog2(MAX_ROW_BEATS);
	localparam int TAPS = layer_geom_pkg::ROW_TAPS;

	// scheduler to read master
	logic                   fetch_req;
	logic                   fetch_ack;
	logic [ADDR_WIDTH-1:0]  fetch_addr;
	logic                   beat_we;
	logic                   beat_last;
	layer_geom_pkg::beat_t  beat_data;

	// bank write and read
	logic [TAPS-1:0]        wr_en;
	logic                   wr_bank;
	logic [AW-1:0]          wr_addr;
	logic                   rd_bank;
	logic [AW-1:0]          rd_addr;
	layer_geom_pkg::beat_t  rd_data [TAPS];

	// ping-pong handoff
	logic [1:0]             bank_full;
	logic [1:0]             bank_release;
	logic [1:0][TAPS-1:0]   pad_mask;
	logic [1:0]             last_job;

	axi_read_master #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_axi_read_master (
		.clk       (clk),
		.reset_n   (reset_n),
		.fetch_req (fetch_req),
		.fetch_addr(fetch_addr),
		.row_beats (row_beats),
		.fetch_ack (fetch_ack),
		.araddr    (araddr),
		.arlen     (arlen),
		.arvalid   (arvalid),
		.arready   (arready),
		.rvalid    (rvalid),
		.rdata     (rdata),
		.rlast     (rlast),
		.rready    (rready),
		.beat_we   (beat_we),
		.beat_data (beat_data),
		.beat_last (beat_last)
	);

	row_fetch_scheduler #(
		.MAX_ROW_BEATS(MAX_ROW_BEATS),
		.ADDR_WIDTH   (ADDR_WIDTH)
	) i_row_fetch_scheduler (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.base_address(base_address),
		.num_layers  (num_layers),
		.num_rows    (num_rows),
		.row_pitch   (row_pitch),
		.beat_we     (beat_we),
		.beat_last   (beat_last),
		.fetch_ack   (fetch_ack),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.wr_en       (wr_en),
		.wr_bank     (wr_bank),
		.wr_addr     (wr_addr),
		.bank_release(bank_release),
		.bank_full   (bank_full),
		.pad_mask    (pad_mask),
		.last_job    (last_job)
	);

	// one bank per window row
	for (genvar k = 0; k < TAPS; k++) begin : g_bank
		row_bank #(
			.MAX_ROW_BEATS(MAX_ROW_BEATS)
		) i_row_bank (
			.clk    (clk),
			.wr_en  (wr_en[k]),
			.wr_bank(wr_bank),
			.wr_addr(wr_addr),
			.wr_data(beat_data),
			.rd_bank(rd_bank),
			.rd_addr(rd_addr),
			.rd_data(rd_data[k])
		);
	end

	window_streamer #(
		.MAX_ROW_BEATS(MAX_ROW_BEATS)
	) i_window_streamer (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.num_cols    (num_cols),
		.bank_full   (bank_full),
		.pad_mask    (pad_mask),
		.last_job    (last_job),
		.bank_release(bank_release),
		.rd_bank     (rd_bank),
		.rd_addr     (rd_addr),
		.rd_data0    (rd_data[0]),
		.rd_data1    (rd_data[1]),
		.rd_data2    (rd_data[2]),
		.window_data (window_data),
		.window_valid(window_valid),
		.window_ready(window_ready),
		.run_done    (run_done)
	);

endmodule

// ==== src/window_streamer.sv ====
// reads a full ping-pong bank and streams one padded 3x3 window per column
// each tap keeps its current beat, the RAM output holds the next one
// releases the bank after the last column and pulses run_done on the final job

module window_streamer #(
	parameter int MAX_ROW_BEATS = 8,
	localparam int AW = $clog2(MAX_ROW_BEATS)
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    start,
	input  layer_geom_pkg::count_t  num_cols,

	// handoff from the scheduler
	input  logic [1:0]              bank_full,
	input  logic [1:0][layer_geom_pkg::ROW_TAPS-1:0] pad_mask,
	input  logic [1:0]              last_job,
	output logic [1:0]              bank_release,

	// bank read port
	output logic                    rd_bank,
	output logic [AW-1:0]           rd_addr,
	input  layer_geom_pkg::beat_t   rd_data0,
	input  layer_geom_pkg::beat_t   rd_data1,
	input  layer_geom_pkg::beat_t   rd_data2,

	// window stream
	output layer_geom_pkg::window_t window_data,
	output logic                    window_valid,
	input  logic                    window_ready,
	output logic                    run_done
);

	localparam int TAPS = layer_geom_pkg::ROW_TAPS;
	localparam int LANE_BITS = $clog2(axi_read_pkg::BEAT_BYTES);

	layer_geom_pkg::count_t cfg_cols;
	layer_geom_pkg::count_t col;
	logic                   priming;
	logic                   idle;
	logic                   accept;
	logic                   beat_end;
	logic                   job_end;

	layer_geom_pkg::beat_t  tap_data [TAPS];
	layer_geom_pkg::beat_t  cur_beat [TAPS];
	logic [127:0]           tap_seg [TAPS];
	logic [LANE_BITS:0]     lane [TAPS];
	logic [TAPS-1:0]        col_ok;

	assign tap_data[0] = rd_data0;
	assign tap_data[1] = rd_data1;
	assign tap_data[2] = rd_data2;

	assign idle     = !priming && !window_valid;
	assign accept   = window_valid && window_ready;
	// last column of the current beat
	assign beat_end = col[LANE_BITS-1:0] == '1;
	assign job_end  = accept && col == cfg_cols - layer_geom_pkg::count_t'(1);

	//--------------------------------------------------
	// column walk and bank handoff
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_bank      <= 1'b0;
			rd_addr      <= '0;
			col          <= '0;
			priming      <= 1'b0;
			window_valid <= 1'b0;
			bank_release <= '0;
			run_done     <= 1'b0;
		end else begin
			bank_release <= '0;
			run_done     <= 1'b0;
			if (start && idle) begin
				rd_bank <= 1'b0;
				rd_addr <= '0;
				col     <= '0;
			end else if (idle) begin
				// beat 0 is addressed, go fetch beat 1
				if (bank_full[rd_bank]) begin
					priming <= 1'b1;
					rd_addr <= AW'(1);
				end
			end else if (priming) begin
				priming      <= 1'b0;
				window_valid <= 1'b1;
			end else if (accept) begin
				col <= col + layer_geom_pkg::count_t'(1);
				if (beat_end) begin
					rd_addr <= rd_addr + AW'(1);
				end
				if (job_end) begin
					window_valid          <= 1'b0;
					col                   <= '0;
					rd_addr               <= '0;
					bank_release[rd_bank] <= 1'b1;
					run_done              <= last_job[rd_bank];
					rd_bank               <= ~rd_bank;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && idle) begin
			cfg_cols <= num_cols;
		end
	end

	// current beat moves on at each beat boundary
	always_ff @(posedge clk) begin
		if (priming || (accept && beat_end)) begin
			for (int k = 0; k < TAPS; k++) begin
				cur_beat[k] <= tap_data[k];
			end
		end
	end

	//--------------------------------------------------
	// window assembly
	//--------------------------------------------------
	for (genvar k = 0; k < TAPS; k++) begin : g_tap
		// 16 bytes, current beat low
		assign tap_seg[k] = {tap_data[k], cur_beat[k]};
		// byte lane of column c+k, and whether it is inside the row
		assign lane[k] = {1'b0, col[LANE_BITS-1:0]} + (LANE_BITS + 1)'(k);
		assign col_ok[k] = ({1'b0, col} + 11'(k)) < {1'b0, cfg_cols};
	end

	// tap k fills 24 bits from the top, column c in the high byte
	always_comb begin
		for (int k = 0; k < TAPS; k++) begin
			for (int j = 0; j < TAPS; j++) begin
				if (pad_mask[rd_bank][k] || !col_ok[j]) begin
					window_data[71-24*k-8*j -: 8] = 8'h00;
				end else begin
					window_data[71-24*k-8*j -: 8] = tap_seg[k][8*lane[j] +: 8];
				end
			end
		end
	end

endmodule

// ==== src/row_bank.sv ====
// one row position of the ping-pong row store
// two halves of MAX_ROW_BEATS beats, selected by the bank bit
// read data is registered and comes one cycle after the address

module row_bank #(
	parameter int MAX_ROW_BEATS = 8,
	localparam int AW = $clog2(MAX_ROW_BEATS)
) (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic                  wr_bank,
	input  logic [AW-1:0]         wr_addr,
	input  layer_geom_pkg::beat_t wr_data,
	input  logic                  rd_bank,
	input  logic [AW-1:0]         rd_addr,
	output layer_geom_pkg::beat_t rd_data
);

	// bank bit is the top address bit
	layer_geom_pkg::beat_t mem [2*MAX_ROW_BEATS];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[{wr_bank, wr_addr}] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= mem[{rd_bank, rd_addr}];
	end

endmodule

// ==== src/row_fetch_scheduler.sv ====
// walks output rows (outer) and layers (inner), one job per pair
// each job fetches rows r-1, r, r+1 into one ping-pong bank half
// rows outside the layer are skipped and flagged in pad_mask

module row_fetch_scheduler #(
	parameter int MAX_ROW_BEATS = 8,
	parameter int ADDR_WIDTH = 32,
	localparam int AW = $clog2(MAX_ROW_BEATS)
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   start,
	input  axi_read_pkg::addr_t    base_address,
	input  layer_geom_pkg::count_t num_layers,
	input  layer_geom_pkg::count_t num_rows,
	input  logic [15:0]            row_pitch,

	// read master side
	input  logic                   beat_we,
	input  logic                   beat_last,
	input  logic                   fetch_ack,
	output logic                   fetch_req,
	output logic [ADDR_WIDTH-1:0]  fetch_addr,

	// bank write side
	output logic [layer_geom_pkg::ROW_TAPS-1:0] wr_en,
	output logic                   wr_bank,
	output logic [AW-1:0]          wr_addr,

	// handoff to the streamer
	input  logic [1:0]             bank_release,
	output logic [1:0]             bank_full,
	output logic [1:0][layer_geom_pkg::ROW_TAPS-1:0] pad_mask,
	output logic [1:0]             last_job
);

	localparam logic [1:0] LAST_TAP = 2'(layer_geom_pkg::ROW_TAPS - 1);

	// config sampled on start
	axi_read_pkg::addr_t    cfg_base;
	layer_geom_pkg::count_t cfg_layers;
	layer_geom_pkg::count_t cfg_rows;
	logic [15:0]            cfg_pitch;

	logic                   busy;
	layer_geom_pkg::count_t job_row;
	layer_geom_pkg::count_t job_layer;
	logic [1:0]             tap;
	logic                   fill_bank;
	logic                   receiving;
	layer_geom_pkg::bank_state_e bank_state [2];

	layer_geom_pkg::count_t tap_row;
	axi_read_pkg::addr_t    row_addr;
	logic                   tap_pad;
	logic                   filling;
	logic                   tap_done;
	logic                   final_job;

	//--------------------------------------------------
	// row address and padding for the current tap
	//--------------------------------------------------
	assign tap_row = job_row + layer_geom_pkg::count_t'(tap) - layer_geom_pkg::count_t'(1);
	// top tap of row 0, bottom tap of the last row
	assign tap_pad = (tap == 2'd0 && job_row == '0) ||
		(tap == LAST_TAP && job_row + layer_geom_pkg::count_t'(1) >= cfg_rows);

	// base + layer * 4096 + row * pitch
	assign row_addr = cfg_base +
		(axi_read_pkg::addr_t'(job_layer) << layer_geom_pkg::LAYER_STRIDE_SHIFT) +
		axi_read_pkg::addr_t'(tap_row) * axi_read_pkg::addr_t'(cfg_pitch);
	assign fetch_addr = ADDR_WIDTH'(row_addr);

	assign filling   = bank_state[fill_bank] == layer_geom_pkg::BANK_FILLING;
	assign tap_done  = filling && (tap_pad || (receiving && beat_last));
	assign final_job = job_row == cfg_rows - layer_geom_pkg::count_t'(1) &&
		job_layer == cfg_layers - layer_geom_pkg::count_t'(1);

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			cfg_base   <= base_address;
			cfg_layers <= num_layers;
			cfg_rows   <= num_rows;
			cfg_pitch  <= row_pitch;
		end
	end

	//--------------------------------------------------
	// job walk and bank handoff
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy          <= 1'b0;
			fetch_req     <= 1'b0;
			receiving     <= 1'b0;
			tap           <= 2'd0;
			fill_bank     <= 1'b0;
			job_row       <= '0;
			job_layer     <= '0;
			bank_state[0] <= layer_geom_pkg::BANK_EMPTY;
			bank_state[1] <= layer_geom_pkg::BANK_EMPTY;
			pad_mask      <= '0;
			last_job      <= '0;
		end else begin
			// streamer hands banks back
			for (int i = 0; i < 2; i++) begin
				if (bank_release[i]) begin
					bank_state[i] <= layer_geom_pkg::BANK_EMPTY;
				end
			end
			if (start && !busy) begin
				busy      <= 1'b1;
				job_row   <= '0;
				job_layer <= '0;
				fill_bank <= 1'b0;
			end else if (busy && bank_state[fill_bank] == layer_geom_pkg::BANK_EMPTY) begin
				// claim the bank, start at tap 0
				bank_state[fill_bank] <= layer_geom_pkg::BANK_FILLING;
				pad_mask[fill_bank]   <= '0;
				tap                   <= 2'd0;
			end else if (filling) begin
				if (tap_pad) begin
					pad_mask[fill_bank][tap] <= 1'b1;
				end else if (!fetch_req && !receiving) begin
					fetch_req <= 1'b1;
				end
				if (fetch_req && fetch_ack) begin
					fetch_req <= 1'b0;
					receiving <= 1'b1;
				end
				if (tap_done) begin
					receiving <= 1'b0;
					if (tap == LAST_TAP) begin
						// job complete, hand over and step layer then row
						tap                   <= 2'd0;
						bank_state[fill_bank] <= layer_geom_pkg::BANK_FULL;
						last_job[fill_bank]   <= final_job;
						fill_bank             <= ~fill_bank;
						busy                  <= !final_job;
						if (job_layer == cfg_layers - layer_geom_pkg::count_t'(1)) begin
							job_layer <= '0;
							job_row   <= job_row + layer_geom_pkg::count_t'(1);
						end else begin
							job_layer <= job_layer + layer_geom_pkg::count_t'(1);
						end
					end else begin
						tap <= tap + 2'd1;
					end
				end
			end
		end
	end

	// beat write address, restarts each row
	always_ff @(posedge clk) begin
		if (!reset_n || beat_last) begin
			wr_addr <= '0;
		end else if (beat_we) begin
			wr_addr <= wr_addr + AW'(1);
		end
	end

	always_comb begin
		for (int k = 0; k < layer_geom_pkg::ROW_TAPS; k++) begin
			wr_en[k] = beat_we && tap == 2'(k);
		end
	end

	assign wr_bank = fill_bank;

	for (genvar i = 0; i < 2; i++) begin : g_full
		assign bank_full[i] = bank_state[i] == layer_geom_pkg::BANK_FULL;
	end

endmodule

// ==== src/axi_read_master.sv ====
// AXI4 read master, one INCR burst per fetch request
// takes the address on fetch_req, acks in the arready cycle and
// returns each R beat as a write strobe with its last flag

module axi_read_master #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  reset_n,

	// request from the scheduler
	input  logic                  fetch_req,
	input  logic [ADDR_WIDTH-1:0] fetch_addr,
	input  logic [3:0]            row_beats,
	output logic                  fetch_ack,

	// AR channel
	output logic [ADDR_WIDTH-1:0] araddr,
	output logic [7:0]            arlen,
	output logic                  arvalid,
	input  logic                  arready,

	// R channel
	input  logic                  rvalid,
	input  layer_geom_pkg::beat_t rdata,
	input  logic                  rlast,
	output logic                  rready,

	// beats out to the banks
	output logic                  beat_we,
	output layer_geom_pkg::beat_t beat_data,
	output logic                  beat_last
);

	axi_read_pkg::rd_state_e state;

	//--------------------------------------------------
	// burst FSM
	//--------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state   <= axi_read_pkg::RD_IDLE;
			arvalid <= 1'b0;
			rready  <= 1'b0;
		end else begin
			case (state)
				axi_read_pkg::RD_IDLE: begin
					// new request, raise arvalid next cycle
					if (fetch_req) begin
						arvalid <= 1'b1;
						state   <= axi_read_pkg::RD_ADDR;
					end
				end
				axi_read_pkg::RD_ADDR: begin
					// arvalid holds until the slave takes it
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= axi_read_pkg::RD_DATA;
					end
				end
				axi_read_pkg::RD_DATA: begin
					// only one burst in flight, close on rlast
					if (rvalid && rlast) begin
						rready <= 1'b0;
						state  <= axi_read_pkg::RD_IDLE;
					end
				end
				default: state <= axi_read_pkg::RD_IDLE;
			endcase
		end
	end

	// address and length latched with the request
	always_ff @(posedge clk) begin
		if (state == axi_read_pkg::RD_IDLE && fetch_req) begin
			araddr <= fetch_addr;
			arlen  <= {4'd0, row_beats} - 8'd1;
		end
	end

	assign fetch_ack = (state == axi_read_pkg::RD_ADDR) && arready;

	// beats go straight to the bank write port
	assign beat_we   = rvalid && rready;
	assign beat_data = rdata;
	assign beat_last = beat_we && rlast;

endmodule

// ==== src/axi_read_pkg.sv ====
// AXI4 read-channel definitions for the layer reader master
// the unused AR fields are fixed and are not ports:
// arid 0, arsize BEAT_SIZE_CODE, arburst INCR, arlock 0,
// arcache 4'b0011, arprot 0, arqos 0

package axi_read_pkg;

	// byte address on the AR channel
	typedef logic [31:0] addr_t;

	// AXI burst types
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	// every burst is INCR
	localparam burst_e AR_BURST = BURST_INCR;

	// 8-byte beats
	localparam int BEAT_SIZE_CODE = 3;
	localparam int BEAT_BYTES = 1 << BEAT_SIZE_CODE;

	// read master states
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_e;

endpackage

// ==== src/layer_geom_pkg.sv ====
// stream-side definitions for the input layer reader
// shared by the scheduler, the row banks, the streamer and the top level
// covers window, beat and count types plus the ping-pong bank states

package layer_geom_pkg;

	// one 3x3 window: three 24-bit rows, row r-1 in the top bits
	// inside a row, column c is the high byte
	typedef logic [71:0] window_t;

	// layer, row or column count
	typedef logic [9:0] count_t;

	// one memory beat of eight byte lanes
	// lane 0 holds the low byte
	typedef logic [63:0] beat_t;

	// handoff state of one ping-pong bank
	typedef enum logic [1:0] {
		BANK_EMPTY,
		BANK_FILLING,
		BANK_FULL
	} bank_state_e;

	// layers are 4096 bytes apart
	localparam int LAYER_STRIDE_SHIFT = 12;

	// window height, one row bank per tap
	localparam int ROW_TAPS = 3;

endpackage
